// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath and memory sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen         = 32;   // Data and address width
    localparam int rob_tag_bits = 5;    // Reorder buffer tag
    localparam int mem_words    = 256;  // Word address is adr[9:2]

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Access size and funct3 encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;             // funct3[1:0]

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_op_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_op_e;

    // Who owns the memory bus
    typedef enum logic [1:0] {
        arb_idle  = 2'b00,
        arb_load  = 2'b01,
        arb_store = 2'b10
    } arb_state_e;

endpackage

`default_nettype wire

// File: src/load_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_unit import lsu_pkg::*; (
    input  wire                     clock,
    input  wire                     reset,
    // Issue
    input  wire                     issue_valid,
    input  wire  [rob_tag_bits-1:0] rob_tag,
    input  wire  [xlen-1:0]         rs1_value,
    input  wire  [31:0]             inst,
    output logic                    ready,
    // Result
    input  wire                     cdb_ack,
    output logic                    done,
    output logic [rob_tag_bits-1:0] result_tag,
    output logic [xlen-1:0]         result_value,
    // Wishbone master
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [xlen-1:0]         wb_adr,
    output logic [3:0]              wb_sel,
    input  wire  [xlen-1:0]         wb_dat_r,
    input  wire                     wb_ack
);

    logic            busy;        // Bus cycle in flight
    logic            issue_fire;
    load_op_e        op_q;
    mem_size_e       size;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] adr_q;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] ext_data;

    assign ready      = !busy && !done;
    assign issue_fire = issue_valid && ready;
    assign imm_i      = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign size       = mem_size_e'(op_q[1:0]);

    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_we  = 1'b0;
    assign wb_adr = adr_q;
    assign wb_sel = 4'b1111;   // Whole word, lane picked on return

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane select and extension
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        lane_data = wb_dat_r >> {adr_q[1:0], 3'b000};   // Move addressed lane to bit 0
        ext_data  = lane_data;
        case (op_q)
            lb:  ext_data[xlen-1:8]  = {(xlen-8){lane_data[7]}};
            lbu: ext_data[xlen-1:8]  = '0;
            lh:  ext_data[xlen-1:16] = {(xlen-16){lane_data[15]}};
            lhu: ext_data[xlen-1:16] = '0;
            default: ;                                    // lw keeps all bits
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            if (issue_fire) begin
                busy <= 1'b1;
            end
            if (busy && wb_ack) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            // Ack clear has the last word
            if (cdb_ack) begin
                done <= 1'b0;
            end
        end
    end

    // Issue and result payload
    always_ff @(posedge clock) begin
        if (issue_fire) begin
            result_tag <= rob_tag;
            op_q       <= load_op_e'(inst[14:12]);
            adr_q      <= rs1_value + imm_i;
        end
        if (busy && wb_ack) begin
            result_value <= ext_data;
        end
    end

    // Issue only into an idle unit
    a_issue_ready: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> ready);

    // Misaligned loads are outside the supported set
    a_aligned: assert property (@(posedge clock) disable iff (reset)
        busy |-> !((size == size_word && adr_q[1:0] != 2'b00)
                   || (size == size_half && adr_q[0])));

    // Result stays put until the CDB takes it
    a_result_held: assert property (@(posedge clock) disable iff (reset)
        (done && !cdb_ack) |=> (done && $stable(result_value) && $stable(result_tag)));

endmodule

`default_nettype wire

// File: src/store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module store_unit import lsu_pkg::*; (
    input  wire                     clock,
    input  wire                     reset,
    // Issue
    input  wire                     issue_valid,
    input  wire  [rob_tag_bits-1:0] rob_tag,
    input  wire  [xlen-1:0]         rs1_value,
    input  wire  [xlen-1:0]         rs2_value,
    input  wire  [31:0]             inst,
    output logic                    ready,
    // Result
    input  wire                     cdb_ack,
    output logic                    done,
    output logic [rob_tag_bits-1:0] result_tag,
    // Wishbone master
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [xlen-1:0]         wb_adr,
    output logic [xlen-1:0]         wb_dat_w,
    output logic [3:0]              wb_sel,
    input  wire                     wb_ack
);

    logic            busy;
    logic            issue_fire;
    store_op_e       op;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] dat_lanes;
    logic [3:0]      sel_lanes;
    logic            misaligned;

    assign ready      = !busy && !done;
    assign issue_fire = issue_valid && ready;
    assign op         = store_op_e'(inst[14:12]);
    assign imm_s      = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign addr       = rs1_value + imm_s;

    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_we  = 1'b1;

    // Replicate store data on every lane, enable only the addressed ones
    always_comb begin
        case (op)
            sb: begin
                dat_lanes  = {4{rs2_value[7:0]}};
                sel_lanes  = 4'b0001 << addr[1:0];
                misaligned = 1'b0;
            end
            sh: begin
                dat_lanes  = {2{rs2_value[15:0]}};
                sel_lanes  = 4'b0011 << addr[1:0];
                misaligned = addr[0];
            end
            default: begin                                // sw
                dat_lanes  = rs2_value;
                sel_lanes  = 4'b1111;
                misaligned = (addr[1:0] != 2'b00);
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control and payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            if (issue_fire) begin
                busy <= 1'b1;
            end
            if (busy && wb_ack) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (cdb_ack) begin
                done <= 1'b0;     // Ack clear wins
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            result_tag <= rob_tag;
            wb_adr     <= addr;
            wb_dat_w   <= dat_lanes;
            wb_sel     <= sel_lanes;
        end
    end

    a_issue_ready: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> ready);

    a_aligned: assert property (@(posedge clock) disable iff (reset)
        issue_fire |-> !misaligned);

    // Wishbone rule, request held until the slave acks
    a_bus_held: assert property (@(posedge clock) disable iff (reset)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_dat_w)
                                 && $stable(wb_sel)));

endmodule

`default_nettype wire

// File: src/dmem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module dmem_arbiter import lsu_pkg::*; (
    input  wire              clock,
    input  wire              reset,
    // Load unit master
    input  wire              ld_cyc,
    input  wire              ld_stb,
    input  wire              ld_we,
    input  wire  [xlen-1:0]  ld_adr,
    input  wire  [3:0]       ld_sel,
    output logic [xlen-1:0]  ld_dat_r,
    output logic             ld_ack,
    // Store unit master
    input  wire              st_cyc,
    input  wire              st_stb,
    input  wire              st_we,
    input  wire  [xlen-1:0]  st_adr,
    input  wire  [xlen-1:0]  st_dat_w,
    input  wire  [3:0]       st_sel,
    output logic             st_ack,
    // Memory slave
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output logic [xlen-1:0]  mem_adr,
    output logic [xlen-1:0]  mem_dat_w,
    output logic [3:0]       mem_sel,
    input  wire  [xlen-1:0]  mem_dat_r,
    input  wire              mem_ack
);

    arb_state_e state;
    arb_state_e state_next;
    logic       last_store;   // Store unit was granted last

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        case (state)
            arb_idle: begin
                if (ld_cyc && st_cyc) begin
                    state_next = last_store ? arb_load : arb_store;   // Round robin
                end else if (ld_cyc) begin
                    state_next = arb_load;
                end else if (st_cyc) begin
                    state_next = arb_store;
                end
            end
            arb_load:  if (!ld_cyc) state_next = arb_idle;
            arb_store: if (!st_cyc) state_next = arb_idle;
            default:   state_next = arb_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= arb_idle;
            last_store <= 1'b0;
        end else begin
            state <= state_next;
            if (state == arb_idle && state_next == arb_load) begin
                last_store <= 1'b0;
            end else if (state == arb_idle && state_next == arb_store) begin
                last_store <= 1'b1;
            end
        end
    end

    // Route the granted master to the memory
    always_comb begin
        mem_cyc   = 1'b0;
        mem_stb   = 1'b0;
        mem_we    = 1'b0;
        mem_adr   = '0;
        mem_dat_w = '0;
        mem_sel   = '0;
        case (state)
            arb_load: begin
                mem_cyc = ld_cyc;
                mem_stb = ld_stb;
                mem_we  = ld_we;
                mem_adr = ld_adr;
                mem_sel = ld_sel;
            end
            arb_store: begin
                mem_cyc   = st_cyc;
                mem_stb   = st_stb;
                mem_we    = st_we;
                mem_adr   = st_adr;
                mem_dat_w = st_dat_w;
                mem_sel   = st_sel;
            end
            default: ;
        endcase
    end

    assign ld_dat_r = mem_dat_r;
    assign ld_ack   = (state == arb_load)  && mem_ack;
    assign st_ack   = (state == arb_store) && mem_ack;

    a_one_ack: assert property (@(posedge clock) disable iff (reset)
        !(ld_ack && st_ack));

endmodule

`default_nettype wire

// File: src/data_memory.sv
`timescale 1ns/10ps
`default_nettype none

module data_memory import lsu_pkg::*; (
    input  wire              clock,
    input  wire              reset,
    input  wire              cyc,
    input  wire              stb,
    input  wire              we,
    input  wire  [xlen-1:0]  adr,
    input  wire  [xlen-1:0]  dat_w,
    input  wire  [3:0]       sel,
    output logic [xlen-1:0]  dat_r,
    output logic             ack
);

    logic [xlen-1:0]              mem [mem_words];
    logic [$clog2(mem_words)-1:0] word_adr;
    logic                         strobe;

    assign word_adr = adr[$clog2(mem_words)+1:2];
    assign strobe   = cyc && stb && !ack;     // Not the strobe being acked now

    // Contents start out zero
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte-lane write, word read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clock) begin
        if (strobe && we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (sel[lane]) begin
                    mem[word_adr][8*lane +: 8] <= dat_w[8*lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (strobe) begin
            dat_r <= mem[word_adr];   // Valid in the ack cycle
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= strobe;
        end
    end

    a_adr_range: assert property (@(posedge clock) disable iff (reset)
        (cyc && stb) |-> (adr < xlen'(mem_words * 4)));

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  wire                     clock,
    input  wire                     reset,
    // Load unit issue and result
    input  wire                     ld_issue_valid,
    input  wire  [rob_tag_bits-1:0] ld_rob_tag,
    input  wire  [xlen-1:0]         ld_rs1_value,
    input  wire  [31:0]             ld_inst,
    input  wire                     ld_cdb_ack,
    output logic                    ld_ready,
    output logic                    ld_done,
    output logic [rob_tag_bits-1:0] ld_result_tag,
    output logic [xlen-1:0]         ld_result_value,
    // Store unit issue and result
    input  wire                     st_issue_valid,
    input  wire  [rob_tag_bits-1:0] st_rob_tag,
    input  wire  [xlen-1:0]         st_rs1_value,
    input  wire  [xlen-1:0]         st_rs2_value,
    input  wire  [31:0]             st_inst,
    input  wire                     st_cdb_ack,
    output logic                    st_ready,
    output logic                    st_done,
    output logic [rob_tag_bits-1:0] st_result_tag
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone nets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic            ld_wb_cyc, ld_wb_stb, ld_wb_we, ld_wb_ack;
    logic [xlen-1:0] ld_wb_adr, ld_wb_dat_r;
    logic [3:0]      ld_wb_sel;

    logic            st_wb_cyc, st_wb_stb, st_wb_we, st_wb_ack;
    logic [xlen-1:0] st_wb_adr, st_wb_dat_w;
    logic [3:0]      st_wb_sel;

    logic            mem_cyc, mem_stb, mem_we, mem_ack;
    logic [xlen-1:0] mem_adr, mem_dat_w, mem_dat_r;
    logic [3:0]      mem_sel;

    load_unit i_load_unit (
        .clock, .reset,
        .issue_valid (ld_issue_valid),  .rob_tag    (ld_rob_tag),
        .rs1_value   (ld_rs1_value),    .inst       (ld_inst),
        .ready       (ld_ready),        .cdb_ack    (ld_cdb_ack),
        .done        (ld_done),         .result_tag (ld_result_tag),
        .result_value(ld_result_value),
        .wb_cyc      (ld_wb_cyc),       .wb_stb     (ld_wb_stb),
        .wb_we       (ld_wb_we),        .wb_adr     (ld_wb_adr),
        .wb_sel      (ld_wb_sel),       .wb_dat_r   (ld_wb_dat_r),
        .wb_ack      (ld_wb_ack)
    );

    store_unit i_store_unit (
        .clock, .reset,
        .issue_valid (st_issue_valid),  .rob_tag    (st_rob_tag),
        .rs1_value   (st_rs1_value),    .rs2_value  (st_rs2_value),
        .inst        (st_inst),         .ready      (st_ready),
        .cdb_ack     (st_cdb_ack),      .done       (st_done),
        .result_tag  (st_result_tag),
        .wb_cyc      (st_wb_cyc),       .wb_stb     (st_wb_stb),
        .wb_we       (st_wb_we),        .wb_adr     (st_wb_adr),
        .wb_dat_w    (st_wb_dat_w),     .wb_sel     (st_wb_sel),
        .wb_ack      (st_wb_ack)
    );

    // Load and store share one memory port
    dmem_arbiter i_dmem_arbiter (
        .clock, .reset,
        .ld_cyc   (ld_wb_cyc),   .ld_stb   (ld_wb_stb),   .ld_we  (ld_wb_we),
        .ld_adr   (ld_wb_adr),   .ld_sel   (ld_wb_sel),
        .ld_dat_r (ld_wb_dat_r), .ld_ack   (ld_wb_ack),
        .st_cyc   (st_wb_cyc),   .st_stb   (st_wb_stb),   .st_we  (st_wb_we),
        .st_adr   (st_wb_adr),   .st_dat_w (st_wb_dat_w), .st_sel (st_wb_sel),
        .st_ack   (st_wb_ack),
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_sel,
        .mem_dat_r, .mem_ack
    );

    data_memory i_data_memory (
        .clock, .reset,
        .cyc   (mem_cyc),   .stb   (mem_stb),   .we  (mem_we),
        .adr   (mem_adr),   .dat_w (mem_dat_w), .sel (mem_sel),
        .dat_r (mem_dat_r), .ack   (mem_ack)
    );

endmodule

`default_nettype wire

// File: testbench/tb_lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_top import lsu_pkg::*; ();

    localparam int rand_seed      = 36975;
    localparam int reset_cycles   = 16;
    localparam int partial_rounds = 4;
    localparam int ext_rounds     = 4;
    localparam int stall_rounds   = 4;
    localparam int mix_accesses   = 200;
    localparam int access_count   = 2 + 12 * partial_rounds + 13 * ext_rounds + 5
                                    + 2 * stall_rounds + mix_accesses;
    localparam int timeout_cycles = 64 * access_count + reset_cycles;

    logic                    clock;
    logic                    reset;
    logic                    ld_issue_valid, ld_cdb_ack, ld_ready, ld_done;
    logic [rob_tag_bits-1:0] ld_rob_tag, ld_result_tag;
    logic [xlen-1:0]         ld_rs1_value, ld_result_value;
    logic [31:0]             ld_inst;
    logic                    st_issue_valid, st_cdb_ack, st_ready, st_done;
    logic [rob_tag_bits-1:0] st_rob_tag, st_result_tag;
    logic [xlen-1:0]         st_rs1_value, st_rs2_value;
    logic [31:0]             st_inst;

    logic [7:0] ref_mem [0:4*mem_words-1];   // Byte-wide reference model
    int         cycle_count = 0;

    lsu_top i_lsu_top (
        .clock, .reset,
        .ld_issue_valid, .ld_rob_tag, .ld_rs1_value, .ld_inst, .ld_cdb_ack,
        .ld_ready, .ld_done, .ld_result_tag, .ld_result_value,
        .st_issue_valid, .st_rob_tag, .st_rs1_value, .st_rs2_value, .st_inst,
        .st_cdb_ack, .st_ready, .st_done, .st_result_tag
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // 4 ns period
    end

    // Run length guard
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: run took more than %0d cycles", timeout_cycles);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [31:0] expected_load(input logic [2:0] funct3,
                                                  input logic [31:0] addr);
        logic [9:0] a;
        logic [7:0] b0, b1, b2, b3;
        a  = addr[9:0];
        b0 = ref_mem[a];
        b1 = ref_mem[a + 10'd1];
        b2 = ref_mem[a + 10'd2];
        b3 = ref_mem[a + 10'd3];
        case (funct3)
            lb:      return {{24{b0[7]}}, b0};
            lbu:     return {24'd0, b0};
            lh:      return {{16{b1[7]}}, b1, b0};
            lhu:     return {16'd0, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic void update_model(input logic [2:0] funct3, input logic [31:0] addr,
                                         input logic [31:0] data);
        logic [9:0] a;
        a = addr[9:0];
        ref_mem[a] = data[7:0];
        if (funct3 != sb) begin
            ref_mem[a + 10'd1] = data[15:8];
        end
        if (funct3 == sw) begin
            ref_mem[a + 10'd2] = data[23:16];
            ref_mem[a + 10'd3] = data[31:24];
        end
    endfunction

    function automatic logic [31:0] encode_load(input logic [2:0] funct3,
                                                input logic [11:0] imm);
        return {imm, 5'd2, funct3, 5'd10, 7'b0000011};            // I-type, rd x10
    endfunction

    function automatic logic [31:0] encode_store(input logic [2:0] funct3,
                                                 input logic [11:0] imm);
        return {imm[11:5], 5'd11, 5'd2, funct3, imm[4:0], 7'b0100011};   // S-type
    endfunction

    // Aligned byte address for the size in funct3[1:0]
    function automatic logic [31:0] random_addr(input logic [1:0] size);
        logic [7:0] word;
        logic [1:0] offset;
        word = 8'($urandom_range(0, mem_words - 1));
        case (size)
            size_byte: offset = 2'($urandom_range(0, 3));
            size_half: offset = {1'($urandom_range(0, 1)), 1'b0};
            default:   offset = 2'b00;
        endcase
        return {22'd0, word, offset};
    endfunction

    function automatic logic [2:0] random_load_op();
        case ($urandom_range(0, 4))
            0:       return lb;
            1:       return lh;
            2:       return lw;
            3:       return lbu;
            default: return lhu;
        endcase
    endfunction

    function automatic logic [2:0] random_store_op();
        case ($urandom_range(0, 2))
            0:       return sb;
            1:       return sh;
            default: return sw;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single accesses, issue to CDB acknowledge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_access(input logic [2:0] funct3, input logic [31:0] addr,
                               input int hold);
        logic [11:0] imm;
        logic [4:0]  tag;
        logic [31:0] expected;
        imm      = 12'($urandom_range(0, 4095));
        tag      = 5'($urandom_range(0, 31));
        expected = expected_load(funct3, addr);   // Contents before the load
        while (!ld_ready) @(negedge clock);
        ld_issue_valid = 1'b1;
        ld_rob_tag     = tag;
        ld_rs1_value   = addr - {{20{imm[11]}}, imm};
        ld_inst        = encode_load(funct3, imm);
        @(negedge clock);
        ld_issue_valid = 1'b0;
        while (!ld_done) @(negedge clock);
        check_value(32'(ld_result_tag), 32'(tag), "load tag");
        check_value(ld_result_value, expected, "load value");
        repeat (hold) begin
            @(negedge clock);
            check_value(32'(ld_done), 32'd1, "load done held");
            check_value(32'(ld_ready), 32'd0, "load ready while done");
            check_value(32'(ld_result_tag), 32'(tag), "load tag held");
            check_value(ld_result_value, expected, "load value held");
        end
        ld_cdb_ack = 1'b1;
        @(negedge clock);
        ld_cdb_ack = 1'b0;
        check_value(32'(ld_done), 32'd0, "load done after ack");
        check_value(32'(ld_ready), 32'd1, "load ready after ack");
    endtask

    task automatic store_access(input logic [2:0] funct3, input logic [31:0] addr,
                                input logic [31:0] data, input int hold);
        logic [11:0] imm;
        logic [4:0]  tag;
        imm = 12'($urandom_range(0, 4095));
        tag = 5'($urandom_range(0, 31));
        update_model(funct3, addr, data);
        while (!st_ready) @(negedge clock);
        st_issue_valid = 1'b1;
        st_rob_tag     = tag;
        st_rs1_value   = addr - {{20{imm[11]}}, imm};
        st_rs2_value   = data;
        st_inst        = encode_store(funct3, imm);
        @(negedge clock);
        st_issue_valid = 1'b0;
        while (!st_done) @(negedge clock);
        check_value(32'(st_result_tag), 32'(tag), "store tag");
        repeat (hold) begin
            @(negedge clock);
            check_value(32'(st_done), 32'd1, "store done held");
            check_value(32'(st_ready), 32'd0, "store ready while done");
            check_value(32'(st_result_tag), 32'(tag), "store tag held");
        end
        st_cdb_ack = 1'b1;
        @(negedge clock);
        st_cdb_ack = 1'b0;
        check_value(32'(st_done), 32'd0, "store done after ack");
        check_value(32'(st_ready), 32'd1, "store ready after ack");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic word_roundtrip();
        logic [31:0] addr;
        check_value(32'(ld_ready), 32'd1, "ld_ready after reset");
        check_value(32'(st_ready), 32'd1, "st_ready after reset");
        check_value(32'(ld_done), 32'd0, "ld_done after reset");
        check_value(32'(st_done), 32'd0, "st_done after reset");
        addr = random_addr(size_word);
        store_access(sw, addr, $urandom, 0);
        load_access(lw, addr, 0);
    endtask

    // Every sub-word store is followed by a word read of the same word
    task automatic partial_stores();
        logic [31:0] base;
        for (int round = 0; round < partial_rounds; round++) begin
            base = random_addr(size_word);
            for (int off = 0; off < 4; off++) begin
                store_access(sb, base + 32'(off), $urandom, 0);
                load_access(lw, base, 0);
            end
            for (int off = 0; off < 4; off += 2) begin
                store_access(sh, base + 32'(off), $urandom, 0);
                load_access(lw, base, 0);
            end
        end
    endtask

    task automatic load_extension();
        logic [31:0] base;
        logic [31:0] data;
        for (int round = 0; round < ext_rounds; round++) begin
            base = random_addr(size_word);
            data = $urandom;
            data = (round % 2 == 0) ? (data | 32'h8080_8080) : (data & 32'h7f7f_7f7f);
            store_access(sw, base, data, 0);
            for (int off = 0; off < 4; off++) begin
                load_access(lb, base + 32'(off), 0);
                load_access(lbu, base + 32'(off), 0);
            end
            for (int off = 0; off < 4; off += 2) begin
                load_access(lh, base + 32'(off), 0);
                load_access(lhu, base + 32'(off), 0);
            end
        end
    endtask

    task automatic parallel_access();
        logic [31:0] st_addr;
        logic [31:0] ld_addr;
        ld_addr = random_addr(size_word);
        st_addr = random_addr(size_word);
        while (st_addr[9:2] == ld_addr[9:2]) st_addr = random_addr(size_word);
        store_access(sw, ld_addr, $urandom, 0);   // Known prior contents
        fork
            store_access(sw, st_addr, $urandom, 0);
            load_access(lw, ld_addr, 0);
        join
        load_access(lw, st_addr, 0);
        load_access(lw, ld_addr, 0);
    endtask

    task automatic result_backpressure();
        logic [2:0] op;
        for (int round = 0; round < stall_rounds; round++) begin
            op = random_store_op();
            store_access(op, random_addr(op[1:0]), $urandom, $urandom_range(0, 10));
            op = random_load_op();
            load_access(op, random_addr(op[1:0]), $urandom_range(0, 10));
        end
    endtask

    task automatic random_mix();
        int          n;
        logic        load_turn;
        logic [2:0]  ld_op, st_op;
        logic [31:0] ld_addr, st_addr;
        n         = 0;
        load_turn = 1'b0;
        while (n < mix_accesses) begin
            ld_op   = random_load_op();
            st_op   = random_store_op();
            ld_addr = random_addr(ld_op[1:0]);
            st_addr = random_addr(st_op[1:0]);
            if ($urandom_range(0, 3) == 0 && n <= mix_accesses - 2) begin
                // Both units at once, on different words
                while (st_addr[9:2] == ld_addr[9:2]) st_addr = random_addr(st_op[1:0]);
                fork
                    load_access(ld_op, ld_addr, $urandom_range(0, 2));
                    store_access(st_op, st_addr, $urandom, $urandom_range(0, 2));
                join
                n += 2;
            end else begin
                if (load_turn) begin
                    load_access(ld_op, ld_addr, $urandom_range(0, 2));
                end else begin
                    store_access(st_op, st_addr, $urandom, $urandom_range(0, 2));
                end
                n++;
            end
            load_turn = !load_turn;
        end
    endtask

    initial begin
        void'($urandom(rand_seed));
        for (int i = 0; i < 4 * mem_words; i++) begin
            ref_mem[i] = 8'h00;   // Memory powers up zeroed
        end
        reset          = 1'b1;
        ld_issue_valid = 1'b0;
        ld_rob_tag     = '0;
        ld_rs1_value   = '0;
        ld_inst        = '0;
        ld_cdb_ack     = 1'b0;
        st_issue_valid = 1'b0;
        st_rob_tag     = '0;
        st_rs1_value   = '0;
        st_rs2_value   = '0;
        st_inst        = '0;
        st_cdb_ack     = 1'b0;
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;

        word_roundtrip();
        partial_stores();
        load_extension();
        parallel_access();
        result_backpressure();
        random_mix();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/lsu_pkg.sv
src/load_unit.sv
src/store_unit.sv
src/dmem_arbiter.sv
src/data_memory.sv
src/lsu_top.sv
testbench/tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# Build the load/store subsystem testbench with Verilator and run it.
# The exit status of the simulation is the exit status of this script.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    -f files.f --top-module tb_lsu_top -o sim_lsu_top &&
./obj_dir/sim_lsu_top ||
exit 1
